//--- rv_defines.svh
`ifndef RV_DEFINES_SVH
`define RV_DEFINES_SVH

// Data and address width
`define XLEN 32

// Architectural register file
`define NUM_REGS 32
`define REG_IDX_W 5

// First fetch address out of reset
`define PC_RESET 32'h0000_0000

// Byte step between sequential instructions
`define INSN_BYTES 4

`endif

//--- rv_pkg.sv
package rv_pkg;

  // Major opcodes handled by the core
  typedef enum logic [6:0] {
    OPC_LUI      = 7'b0110111,
    OPC_AUIPC    = 7'b0010111,
    OPC_JAL      = 7'b1101111,
    OPC_JALR     = 7'b1100111,
    OPC_BRANCH   = 7'b1100011,
    OPC_OP_IMM   = 7'b0010011,
    OPC_OP       = 7'b0110011,
    OPC_MISC_MEM = 7'b0001111,   // FENCE
    OPC_SYSTEM   = 7'b1110011    // ECALL
  } opcode_e;

  typedef enum logic [3:0] {
    ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU,
    ALU_XOR, ALU_SRL, ALU_SRA, ALU_OR, ALU_AND
  } alu_op_e;

  // Write-back source
  typedef enum logic [1:0] {
    WB_ALU,
    WB_IMM,    // LUI
    WB_LINK    // PC + step for JAL/JALR
  } wb_sel_e;

  // Branch and jump kinds seen by the PC unit
  typedef enum logic [3:0] {
    BR_NONE, BR_EQ, BR_NE, BR_LT, BR_GE, BR_LTU, BR_GEU, BR_JAL, BR_JALR
  } br_kind_e;

  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    opcode_e    opcode;
  } r_fmt_t;

  typedef struct packed {
    logic [11:0] imm_11_0;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    opcode_e     opcode;
  } i_fmt_t;

  typedef struct packed {
    logic       imm_12;
    logic [5:0] imm_10_5;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [3:0] imm_4_1;
    logic       imm_11;
    opcode_e    opcode;
  } b_fmt_t;

  typedef struct packed {
    logic       imm_20;
    logic [9:0] imm_10_1;
    logic       imm_11;
    logic [7:0] imm_19_12;
    logic [4:0] rd;
    opcode_e    opcode;
  } j_fmt_t;

  typedef struct packed {
    logic [19:0] imm_31_12;
    logic [4:0]  rd;
    opcode_e     opcode;
  } u_fmt_t;

  // One instruction word, viewed per format
  typedef union packed {
    r_fmt_t r;
    i_fmt_t i;
    b_fmt_t b;
    j_fmt_t j;
    u_fmt_t u;
  } rv_insn_u;

endpackage

//--- decode_if.sv
`timescale 1ns/1ps
`include "rv_defines.svh"

// Decoded control for the instruction in flight this cycle
interface decode_if import rv_pkg::*; ();
  logic [`REG_IDX_W-1:0] rd;
  logic [`REG_IDX_W-1:0] rs1;
  logic [`REG_IDX_W-1:0] rs2;
  logic [`XLEN-1:0]      imm;        // Sign-extended for the current format
  alu_op_e               alu_op;
  logic                  a_is_pc;    // AUIPC
  logic                  b_is_imm;
  wb_sel_e               wb_sel;
  logic                  rf_we;
  br_kind_e              br_kind;
  logic                  halt;

  modport dec (
    output rd, rs1, rs2, imm, alu_op, a_is_pc, b_is_imm,
    output wb_sel, rf_we, br_kind, halt
  );

  modport exe (input alu_op, a_is_pc, b_is_imm, imm);

  modport ctl (input br_kind, imm, halt);

endinterface

//--- rv_decoder.sv
`timescale 1ns/1ps
`include "rv_defines.svh"

module rv_decoder import rv_pkg::*; (
  input  rv_insn_u insn,
  decode_if.dec    dec
);

  logic [2:0]       funct3;
  logic [6:0]       funct7;
  logic [`XLEN-1:0] imm_i;
  logic [`XLEN-1:0] imm_b;
  logic [`XLEN-1:0] imm_j;
  logic [`XLEN-1:0] imm_u;

  assign funct3 = insn.r.funct3;
  assign funct7 = insn.r.funct7;

  // Immediates, each rebuilt from its own format view
  assign imm_i = {{(`XLEN-12){insn.i.imm_11_0[11]}}, insn.i.imm_11_0};
  assign imm_b = {{(`XLEN-13){insn.b.imm_12}}, insn.b.imm_12, insn.b.imm_11,
                  insn.b.imm_10_5, insn.b.imm_4_1, 1'b0};
  assign imm_j = {{(`XLEN-21){insn.j.imm_20}}, insn.j.imm_20, insn.j.imm_19_12,
                  insn.j.imm_11, insn.j.imm_10_1, 1'b0};
  assign imm_u = {insn.u.imm_31_12, 12'b0};

  // funct3 to ALU op, shared by OP and OP-IMM
  function automatic alu_op_e base_op(input logic [2:0] f3);
    case (f3)
      3'b000:  return ALU_ADD;
      3'b001:  return ALU_SLL;
      3'b010:  return ALU_SLT;
      3'b011:  return ALU_SLTU;
      3'b100:  return ALU_XOR;
      3'b101:  return ALU_SRL;
      3'b110:  return ALU_OR;
      default: return ALU_AND;
    endcase
  endfunction

  always_comb begin
    dec.rd       = insn.r.rd;
    dec.rs1      = insn.r.rs1;
    dec.rs2      = insn.r.rs2;
    dec.imm      = imm_i;
    dec.alu_op   = ALU_ADD;
    dec.a_is_pc  = 1'b0;
    dec.b_is_imm = 1'b0;
    dec.wb_sel   = WB_ALU;
    dec.rf_we    = 1'b0;       // Anything not matched below is a no-op
    dec.br_kind  = BR_NONE;
    dec.halt     = 1'b0;

    case (insn.r.opcode)
      OPC_LUI: begin
        dec.imm    = imm_u;
        dec.wb_sel = WB_IMM;
        dec.rf_we  = 1'b1;
      end
      OPC_AUIPC: begin
        dec.imm      = imm_u;
        dec.a_is_pc  = 1'b1;
        dec.b_is_imm = 1'b1;
        dec.rf_we    = 1'b1;
      end
      OPC_JAL: begin
        dec.imm     = imm_j;
        dec.br_kind = BR_JAL;
        dec.wb_sel  = WB_LINK;
        dec.rf_we   = 1'b1;
      end
      OPC_JALR: begin
        if (funct3 == 3'b000) begin
          dec.b_is_imm = 1'b1;  // Target is rs1 + imm through the ALU
          dec.br_kind  = BR_JALR;
          dec.wb_sel   = WB_LINK;
          dec.rf_we    = 1'b1;
        end
      end
      OPC_BRANCH: begin
        dec.imm = imm_b;
        case (funct3)
          3'b000:  dec.br_kind = BR_EQ;
          3'b001:  dec.br_kind = BR_NE;
          3'b100:  dec.br_kind = BR_LT;
          3'b101:  dec.br_kind = BR_GE;
          3'b110:  dec.br_kind = BR_LTU;
          3'b111:  dec.br_kind = BR_GEU;
          default: dec.br_kind = BR_NONE;
        endcase
      end
      OPC_OP_IMM: begin
        dec.b_is_imm = 1'b1;
        dec.alu_op   = base_op(funct3);
        if (funct3 == 3'b001) begin
          dec.rf_we = (funct7 == 7'b0000000);   // SLLI
        end else if (funct3 == 3'b101) begin
          // Bit 30 picks SRAI over SRLI
          dec.rf_we = (funct7 == 7'b0000000) || (funct7 == 7'b0100000);
          if (funct7 == 7'b0100000) dec.alu_op = ALU_SRA;
        end else begin
          dec.rf_we = 1'b1;
        end
      end
      OPC_OP: begin
        if (funct7 == 7'b0000000) begin
          dec.alu_op = base_op(funct3);
          dec.rf_we  = 1'b1;
        end else if (funct7 == 7'b0100000 && (funct3 == 3'b000 || funct3 == 3'b101)) begin
          dec.alu_op = (funct3 == 3'b000) ? ALU_SUB : ALU_SRA;
          dec.rf_we  = 1'b1;
        end
      end
      OPC_SYSTEM: begin
        dec.halt = (insn.u.imm_31_12 == '0) && (insn.u.rd == '0);  // ECALL only
      end
      default: ;  // FENCE and unknown opcodes
    endcase
  end

endmodule

//--- rv_regfile.sv
`timescale 1ns/1ps
`include "rv_defines.svh"

module rv_regfile (
  input  logic                  clk,
  input  logic                  rst,
  input  logic [`REG_IDX_W-1:0] rs1,
  input  logic [`REG_IDX_W-1:0] rs2,
  input  logic [`REG_IDX_W-1:0] rd,
  input  logic                  we,
  input  logic [`XLEN-1:0]      wdata,
  output logic [`XLEN-1:0]      rs1_data,
  output logic [`XLEN-1:0]      rs2_data
);

  logic [`XLEN-1:0] regs [`NUM_REGS];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < `NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (we && rd != '0) begin  // x0 stays zero
      regs[rd] <= wdata;
    end
  end

  // Reads are combinational, so a write shows up on the next cycle
  assign rs1_data = regs[rs1];
  assign rs2_data = regs[rs2];

  a_x0_stays_zero: assert property (
    @(posedge clk) disable iff (rst)
    (we && rd == '0) |=> (regs[0] == '0)
  );

endmodule

//--- rv_alu.sv
`timescale 1ns/1ps
`include "rv_defines.svh"

module rv_alu import rv_pkg::*; (
  decode_if.exe            exe,
  input  logic [`XLEN-1:0] pc,
  input  logic [`XLEN-1:0] rs1_data,
  input  logic [`XLEN-1:0] rs2_data,
  output logic [`XLEN-1:0] result
);

  logic [`XLEN-1:0] op_a;
  logic [`XLEN-1:0] op_b;
  logic [4:0]       shamt;
  logic             lt_signed;
  logic             lt_unsigned;

  assign op_a = exe.a_is_pc  ? pc      : rs1_data;   // PC only for AUIPC
  assign op_b = exe.b_is_imm ? exe.imm : rs2_data;

  // Only the low five bits count for every shift
  assign shamt = op_b[4:0];

  assign lt_signed   = $signed(op_a) < $signed(op_b);
  assign lt_unsigned = op_a < op_b;

  always_comb begin
    case (exe.alu_op)
      ALU_ADD:  result = op_a + op_b;
      ALU_SUB:  result = op_a - op_b;
      ALU_SLL:  result = op_a << shamt;
      ALU_SLT:  result = {{(`XLEN-1){1'b0}}, lt_signed};
      ALU_SLTU: result = {{(`XLEN-1){1'b0}}, lt_unsigned};
      ALU_XOR:  result = op_a ^ op_b;
      ALU_SRL:  result = op_a >> shamt;
      ALU_SRA:  result = $signed(op_a) >>> shamt;   // Fills with the sign of A
      ALU_OR:   result = op_a | op_b;
      ALU_AND:  result = op_a & op_b;
      default:  result = '0;
    endcase
  end

endmodule

//--- rv_pc_unit.sv
`timescale 1ns/1ps
`include "rv_defines.svh"

module rv_pc_unit import rv_pkg::*; (
  input  logic             clk,
  input  logic             rst,
  decode_if.ctl            ctl,
  input  logic [`XLEN-1:0] rs1_data,
  input  logic [`XLEN-1:0] rs2_data,
  input  logic [`XLEN-1:0] alu_result,
  output logic [`XLEN-1:0] pc,
  output logic [`XLEN-1:0] next_pc
);

  logic [`XLEN-1:0] pc_step;
  logic [`XLEN-1:0] pc_target;
  logic             taken;

  assign pc_step   = pc + `INSN_BYTES;
  assign pc_target = pc + ctl.imm;   // B or J immediate

  always_comb begin
    case (ctl.br_kind)
      BR_EQ:   taken = (rs1_data == rs2_data);
      BR_NE:   taken = (rs1_data != rs2_data);
      BR_LT:   taken = ($signed(rs1_data) <  $signed(rs2_data));
      BR_GE:   taken = ($signed(rs1_data) >= $signed(rs2_data));
      BR_LTU:  taken = (rs1_data <  rs2_data);
      BR_GEU:  taken = (rs1_data >= rs2_data);
      BR_JAL:  taken = 1'b1;
      default: taken = 1'b0;
    endcase
  end

  // Next fetch address, sent to imem and loaded into the PC on the same edge
  always_comb begin
    if (rst) begin
      next_pc = `PC_RESET;
    end else if (ctl.halt) begin
      next_pc = pc;                   // ECALL repeats
    end else if (ctl.br_kind == BR_JALR) begin
      next_pc = {alu_result[`XLEN-1:1], 1'b0};
    end else if (taken) begin
      next_pc = pc_target;
    end else begin
      next_pc = pc_step;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) pc <= `PC_RESET;
    else     pc <= next_pc;
  end

  a_fetch_aligned: assert property (
    @(posedge clk) disable iff (rst) next_pc[1:0] == 2'b00
  );

endmodule

//--- rv_core.sv
`timescale 1ns/1ps
`include "rv_defines.svh"

module rv_core import rv_pkg::*; (
  input  logic                  clk,
  input  logic                  rst,
  input  logic [`XLEN-1:0]      insn_from_imem,
  output logic [`XLEN-1:0]      pc_to_imem,
  output logic                  halt,
  output logic                  wb_we,
  output logic [`REG_IDX_W-1:0] wb_rd,
  output logic [`XLEN-1:0]      wb_data
);

  decode_if dec_bus ();

  logic [`XLEN-1:0] pc;
  logic [`XLEN-1:0] rs1_data;
  logic [`XLEN-1:0] rs2_data;
  logic [`XLEN-1:0] alu_result;
  logic [`XLEN-1:0] link_addr;

  rv_decoder u_decoder (
    .insn (insn_from_imem),
    .dec  (dec_bus.dec)
  );

  rv_regfile u_regfile (
    .clk      (clk),
    .rst      (rst),
    .rs1      (dec_bus.rs1),
    .rs2      (dec_bus.rs2),
    .rd       (dec_bus.rd),
    .we       (wb_we),
    .wdata    (wb_data),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data)
  );

  rv_alu u_alu (
    .exe      (dec_bus.exe),
    .pc       (pc),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data),
    .result   (alu_result)
  );

  rv_pc_unit u_pc_unit (
    .clk        (clk),
    .rst        (rst),
    .ctl        (dec_bus.ctl),
    .rs1_data   (rs1_data),
    .rs2_data   (rs2_data),
    .alu_result (alu_result),
    .pc         (pc),
    .next_pc    (pc_to_imem)
  );

  assign link_addr = pc + `INSN_BYTES;   // Return address for JAL/JALR

  always_comb begin
    case (dec_bus.wb_sel)
      WB_IMM:  wb_data = dec_bus.imm;
      WB_LINK: wb_data = link_addr;
      default: wb_data = alu_result;
    endcase
  end

  // The fetched word is not valid until reset has released
  assign wb_we = dec_bus.rf_we & ~rst;
  assign wb_rd = dec_bus.rd;
  assign halt  = dec_bus.halt & ~rst;

endmodule

//--- tb_rv_core.sv
`timescale 1ns/1ps
`include "rv_defines.svh"

module tb_rv_core import rv_pkg::*; ();

  localparam int IMEM_WORDS = 64;

  logic                  clk;
  logic                  rst;
  logic [`XLEN-1:0]      insn_from_imem;
  logic [`XLEN-1:0]      pc_to_imem;
  logic                  halt;
  logic                  wb_we;
  logic [`REG_IDX_W-1:0] wb_rd;
  logic [`XLEN-1:0]      wb_data;

  logic [`XLEN-1:0] imem [IMEM_WORDS];
  logic [`XLEN-1:0] model_regs [`NUM_REGS];   // Architectural state of the model
  logic [`XLEN-1:0] model_pc;
  int               prog_len = 0;
  bit               program_ready = 1'b0;
  int               checks = 0;
  int               errors = 0;
  int               halted_cycles = 0;

  rv_core DUT (
    .clk            (clk),
    .rst            (rst),
    .insn_from_imem (insn_from_imem),
    .pc_to_imem     (pc_to_imem),
    .halt           (halt),
    .wb_we          (wb_we),
    .wb_rd          (wb_rd),
    .wb_data        (wb_data)
  );

  function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [4:0] rs2,
      input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd);
    rv_insn_u w;
    w.r = '{f7, rs2, rs1, f3, rd, OPC_OP};
    return w;
  endfunction

  function automatic logic [31:0] i_type(input logic [11:0] imm, input logic [4:0] rs1,
      input logic [2:0] f3, input logic [4:0] rd, input opcode_e opc);
    rv_insn_u w;
    w.i = '{imm, rs1, f3, rd, opc};
    return w;
  endfunction

  // Branch offset is in bytes, bit 0 is dropped by the format
  function automatic logic [31:0] b_type(input logic [12:0] off, input logic [4:0] rs2,
      input logic [4:0] rs1, input logic [2:0] f3);
    rv_insn_u w;
    w.b = '{off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], OPC_BRANCH};
    return w;
  endfunction

  function automatic logic [31:0] j_type(input logic [20:0] off, input logic [4:0] rd);
    rv_insn_u w;
    w.j = '{off[20], off[10:1], off[11], off[19:12], rd, OPC_JAL};
    return w;
  endfunction

  function automatic logic [31:0] u_type(input logic [19:0] imm, input logic [4:0] rd,
      input opcode_e opc);
    rv_insn_u w;
    w.u = '{imm, rd, opc};
    return w;
  endfunction

  task automatic emit_insn(input logic [31:0] word);
    imem[prog_len[5:0]] = word;
    prog_len = prog_len + 1;
  endtask

  // Branch over one filler ADDI, so a taken branch skips it
  task automatic emit_skip_branch(input logic [2:0] f3, input logic [4:0] rs1,
      input logic [4:0] rs2);
    emit_insn(b_type(13'd8, rs2, rs1, f3));
    emit_insn(i_type(12'd1, 5'd24, 3'b000, 5'd24, OPC_OP_IMM));
  endtask

  // Integer result by funct3, alt selects SUB or SRA
  function automatic logic [31:0] alu_result_of(input logic [2:0] f3, input logic alt,
      input logic [31:0] x, input logic [31:0] y);
    case (f3)
      3'b000:  return alt ? x - y : x + y;
      3'b001:  return x << y[4:0];
      3'b010:  return ($signed(x) < $signed(y)) ? 32'd1 : 32'd0;
      3'b011:  return (x < y) ? 32'd1 : 32'd0;
      3'b100:  return x ^ y;
      3'b101:  return alt ? 32'($signed(x) >>> y[4:0]) : x >> y[4:0];
      3'b110:  return x | y;
      default: return x & y;
    endcase
  endfunction

  // One instruction of the ISA model: expected write-back and next fetch address
  function automatic void model_step(input logic [31:0] insn, input logic [31:0] pc,
      output logic exp_we, output logic [4:0] exp_rd, output logic [31:0] exp_data,
      output logic [31:0] exp_next, output logic exp_halt);
    logic [6:0]  opc;
    logic [2:0]  f3;
    logic [6:0]  f7;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] imm_i;
    logic [31:0] imm_b;
    logic [31:0] imm_j;
    logic        take;
    opc   = insn[6:0];
    f3    = insn[14:12];
    f7    = insn[31:25];
    a     = model_regs[insn[19:15]];
    b     = model_regs[insn[24:20]];
    imm_i = {{20{insn[31]}}, insn[31:20]};
    imm_b = {{19{insn[31]}}, insn[31], insn[7], insn[30:25], insn[11:8], 1'b0};
    imm_j = {{11{insn[31]}}, insn[31], insn[19:12], insn[20], insn[30:21], 1'b0};
    take     = 1'b0;
    exp_we   = 1'b0;
    exp_rd   = insn[11:7];
    exp_data = 32'd0;
    exp_next = pc + 32'd4;
    exp_halt = 1'b0;
    case (opc)
      OPC_LUI: begin
        exp_we   = 1'b1;
        exp_data = {insn[31:12], 12'h000};
      end
      OPC_AUIPC: begin
        exp_we   = 1'b1;
        exp_data = pc + {insn[31:12], 12'h000};
      end
      OPC_JAL: begin
        exp_we   = 1'b1;
        exp_data = pc + 32'd4;
        exp_next = pc + imm_j;
      end
      OPC_JALR: if (f3 == 3'b000) begin
        exp_we   = 1'b1;
        exp_data = pc + 32'd4;
        exp_next = (a + imm_i) & ~32'd1;
      end
      OPC_BRANCH: begin
        case (f3)
          3'b000:  take = (a == b);
          3'b001:  take = (a != b);
          3'b100:  take = ($signed(a) < $signed(b));
          3'b101:  take = ($signed(a) >= $signed(b));
          3'b110:  take = (a < b);
          3'b111:  take = (a >= b);
          default: take = 1'b0;
        endcase
        if (take) exp_next = pc + imm_b;
      end
      OPC_OP_IMM: begin
        exp_we = (f3 == 3'b001) ? (f7 == 7'h00) :
                 (f3 == 3'b101) ? (f7 == 7'h00 || f7 == 7'h20) : 1'b1;
        exp_data = alu_result_of(f3, f3 == 3'b101 && insn[30], a, imm_i);
      end
      OPC_OP: begin
        exp_we   = (f7 == 7'h00) || (f7 == 7'h20 && (f3 == 3'b000 || f3 == 3'b101));
        exp_data = alu_result_of(f3, insn[30], a, b);
      end
      OPC_SYSTEM: if (insn[31:7] == 25'd0) begin
        exp_halt = 1'b1;    // ECALL holds the PC
        exp_next = pc;
      end
      default: ;
    endcase
  endfunction

  task automatic check_value(input string name, input logic [31:0] got,
      input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("FAIL %s: got 0x%08h, expected 0x%08h (model pc 0x%08h, t=%0t)",
               name, got, exp, model_pc, $time);
    end
  endtask

  task automatic finish_run;
    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0)
      $display("Simulation PASSED");
    else
      $display("Simulation FAILED");
    $finish;
  endtask

  task automatic build_program;
    logic [31:0] rv [16];
    for (int i = 0; i < 16; i++) begin
      rv[i] = $urandom;
    end
    for (int i = 0; i < IMEM_WORDS; i++) begin
      imem[i] = {i[24:0], 7'b0000000};   // Opcode 0 is unknown, index in the upper bits
    end
    // x1 negative and x2 positive, so signed and unsigned compares disagree
    emit_insn(u_type({1'b1, rv[0][18:0] | 19'h00100}, 5'd1, OPC_LUI));
    emit_insn(i_type(rv[1][11:0], 5'd1, 3'b000, 5'd1, OPC_OP_IMM));
    emit_insn(u_type({1'b0, rv[2][18:0] | 19'h00100}, 5'd2, OPC_LUI));
    emit_insn(i_type(rv[3][11:0], 5'd2, 3'b000, 5'd2, OPC_OP_IMM));
    emit_insn(u_type(rv[4][19:0], 5'd3, OPC_AUIPC));
    emit_insn(i_type(rv[5][11:0], 5'd1, 3'b010, 5'd4, OPC_OP_IMM));   // SLTI
    emit_insn(i_type(rv[6][11:0], 5'd1, 3'b011, 5'd5, OPC_OP_IMM));   // SLTIU
    emit_insn(i_type(rv[7][11:0], 5'd2, 3'b100, 5'd6, OPC_OP_IMM));
    emit_insn(i_type(rv[8][11:0], 5'd1, 3'b110, 5'd7, OPC_OP_IMM));
    emit_insn(i_type(rv[9][11:0], 5'd2, 3'b111, 5'd8, OPC_OP_IMM));
    emit_insn(i_type({7'h00, rv[10][4:0]}, 5'd1, 3'b001, 5'd9, OPC_OP_IMM));
    emit_insn(i_type({7'h00, rv[11][4:0]}, 5'd1, 3'b101, 5'd10, OPC_OP_IMM));
    emit_insn(i_type({7'h20, rv[12][4:0]}, 5'd1, 3'b101, 5'd11, OPC_OP_IMM));  // SRAI
    for (int f = 0; f < 8; f++) begin
      emit_insn(r_type(7'h00, 5'd2, 5'd1, f[2:0], 5'(12 + f)));
    end
    emit_insn(r_type(7'h20, 5'd1, 5'd2, 3'b000, 5'd20));   // SUB
    emit_insn(r_type(7'h20, 5'd2, 5'd1, 3'b101, 5'd21));   // SRA of a negative value
    // Writes to x0, then reads of x0
    emit_insn(i_type(rv[13][11:0], 5'd1, 3'b000, 5'd0, OPC_OP_IMM));
    emit_insn(r_type(7'h00, 5'd1, 5'd2, 3'b000, 5'd0));
    emit_insn(r_type(7'h00, 5'd2, 5'd0, 3'b000, 5'd22));
    emit_insn(r_type(7'h00, 5'd0, 5'd1, 3'b000, 5'd23));
    // Each branch kind, first taken and then not taken
    emit_skip_branch(3'b000, 5'd1, 5'd1);
    emit_skip_branch(3'b000, 5'd1, 5'd2);
    emit_skip_branch(3'b001, 5'd1, 5'd2);
    emit_skip_branch(3'b001, 5'd1, 5'd1);
    emit_skip_branch(3'b100, 5'd1, 5'd2);
    emit_skip_branch(3'b100, 5'd2, 5'd1);
    emit_skip_branch(3'b101, 5'd2, 5'd1);
    emit_skip_branch(3'b101, 5'd1, 5'd2);
    emit_skip_branch(3'b110, 5'd2, 5'd1);
    emit_skip_branch(3'b110, 5'd1, 5'd2);
    emit_skip_branch(3'b111, 5'd1, 5'd2);
    emit_skip_branch(3'b111, 5'd2, 5'd1);
    emit_insn(j_type(21'd8, 5'd25));
    emit_insn(i_type(12'd1, 5'd24, 3'b000, 5'd24, OPC_OP_IMM));
    emit_insn(u_type(20'd0, 5'd26, OPC_AUIPC));
    emit_insn(i_type(12'd13, 5'd26, 3'b000, 5'd27, OPC_JALR));   // Odd target
    emit_insn(i_type(12'd1, 5'd24, 3'b000, 5'd24, OPC_OP_IMM));
    emit_insn(i_type(12'h0ff, 5'd0, 3'b000, 5'd0, OPC_MISC_MEM));   // FENCE
    emit_insn(32'hffff_ffff);
    emit_insn(i_type(12'h000, 5'd0, 3'b000, 5'd0, OPC_SYSTEM));
  endtask

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  initial begin
    rst            = 1'b1;
    insn_from_imem = '0;
    void'($urandom(32'h65f1));
    build_program();
    program_ready = 1'b1;
    repeat (16) @(posedge clk);
    rst <= 1'b0;
  end

  // Synchronous instruction memory, one cycle read
  always @(posedge clk) begin
    insn_from_imem <= imem[pc_to_imem[7:2]];
  end

  initial begin : compare
    logic        e_we;
    logic        e_halt;
    logic [4:0]  e_rd;
    logic [31:0] e_data;
    logic [31:0] e_next;
    model_pc = `PC_RESET;
    for (int i = 0; i < `NUM_REGS; i++) begin
      model_regs[i] = '0;
    end
    // ECALL seen, then held for three more cycles
    while (halted_cycles < 4) begin
      @(negedge clk);   // Mid-cycle, all outputs settled
      if (rst) begin
        check_value("pc_to_imem", pc_to_imem, `PC_RESET);
        check_value("wb_we", 32'(wb_we), 32'd0);
        check_value("halt", 32'(halt), 32'd0);
      end else begin
        model_step(imem[model_pc[7:2]], model_pc, e_we, e_rd, e_data, e_next, e_halt);
        check_value("halt", 32'(halt), 32'(e_halt));
        check_value("wb_we", 32'(wb_we), 32'(e_we));
        if (e_we) begin
          check_value("wb_rd", 32'(wb_rd), 32'(e_rd));
          check_value("wb_data", wb_data, e_data);
        end
        check_value("pc_to_imem", pc_to_imem, e_next);
        if (e_we && e_rd != 5'd0) model_regs[e_rd] = e_data;
        model_pc = e_next;
        if (e_halt) halted_cycles++;
      end
    end
    finish_run();
  end

  initial begin
    wait (program_ready);
    #((prog_len + 16 + 20) * 20);
    $display("Timeout: the core never halted within %0d cycles", prog_len + 36);
    errors++;
    finish_run();
  end

endmodule

//--- sim.f
+incdir+.
rv_pkg.sv
decode_if.sv
rv_decoder.sv
rv_regfile.sv
rv_alu.sv
rv_pc_unit.sv
rv_core.sv
tb_rv_core.sv

//--- Makefile
VERILATOR  ?= verilator
TOP        := tb_rv_core
FILELIST   := sim.f
OBJ_DIR    := obj_dir
BUILD_FLAGS := --binary --timing --assert -j 0
LINT_FLAGS := --lint-only -Wall --timing
PASS_MSG   := Simulation PASSED

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(BUILD_FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
